// File: lake_pkg.sv
`default_nettype none

package lake_pkg;

  // configuration and counter words.
  localparam int cfg_w = 16;
  typedef logic [cfg_w-1:0] cfg_word_t;

  // weight memory geometry.
  localparam int mem_depth  = 512;
  localparam int mem_addr_w = 9;
  typedef logic [mem_addr_w-1:0] mem_addr_t;

  localparam int data_w = 64;
  typedef logic [data_w-1:0] data_t;

  typedef logic [3:0] dim_cnt_t; // number of active loop dimensions.

  // schedule gate of an accessor.
  typedef enum logic [0:0] {
    acc_run  = 1'b0,
    acc_done = 1'b1
  } acc_state_t;

endpackage

`default_nettype wire

// File: loop_iterator.sv
`timescale 1ns/10ps
`default_nettype none

module loop_iterator #(
  parameter int num_dims = 4,
  localparam int sel_w = (num_dims > 1) ? $clog2(num_dims) : 1
) (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire                                  clk_en,
  input  wire                                  flush,
  input  wire                                  step,
  input  wire lake_pkg::dim_cnt_t              dimensionality,
  input  wire lake_pkg::cfg_word_t [num_dims-1:0] ranges,
  output logic [sel_w-1:0]                     dim_sel,
  output logic                                 last
);

  import lake_pkg::*;

  cfg_word_t [num_dims-1:0] dim_cnt;
  logic      [num_dims-1:0] active;
  logic      [num_dims-1:0] at_max;
  logic                     found;

  // per-dimension status flags.
  always_comb begin
    for (int d = 0; d < num_dims; d++) begin
      active[d] = dimensionality > dim_cnt_t'(d);
      at_max[d] = dim_cnt[d] == ranges[d]; // range is count minus one.
    end
  end

  // lowest active dimension that still has iterations left.
  always_comb begin
    found   = 1'b0;
    dim_sel = '0;
    for (int d = 0; d < num_dims; d++) begin
      if (!found && active[d] && !at_max[d]) begin
        found   = 1'b1;
        dim_sel = sel_w'(d);
      end
    end
  end

  // all active dimensions sit at their range, so this is the final iteration.
  assign last = ~found;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dim_cnt <= '0;
    end else if (clk_en) begin
      if (flush) begin
        dim_cnt <= '0;
      end else if (step) begin
        for (int d = 0; d < num_dims; d++) begin
          if (last || (d < int'(dim_sel))) begin
            dim_cnt[d] <= '0; // wrap, or clear the inner loops.
          end else if (d == int'(dim_sel)) begin
            dim_cnt[d] <= dim_cnt[d] + cfg_word_t'(1);
          end
        end
      end
    end
  end

  // inactive dimensions never move.
  // the selected counter only advances while below its range.

endmodule

`default_nettype wire

// File: addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

module addr_gen #(
  parameter int num_dims = 4,
  localparam int sel_w = (num_dims > 1) ? $clog2(num_dims) : 1
) (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire                                  clk_en,
  input  wire                                  flush,
  input  wire                                  step,
  input  wire                                  restart,
  input  wire [sel_w-1:0]                      dim_sel,
  input  wire lake_pkg::cfg_word_t             start_addr,
  input  wire lake_pkg::cfg_word_t [num_dims-1:0] strides,
  output lake_pkg::cfg_word_t                  addr
);

  import lake_pkg::*;

  cfg_word_t offset;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      offset <= '0;
    end else if (clk_en) begin
      if (flush) begin
        offset <= '0;
      end else if (step) begin
        if (restart) begin
          offset <= '0; // loop nest wrapped.
        end else begin
          offset <= offset + strides[dim_sel];
        end
      end
    end
  end

  assign addr = start_addr + offset;

endmodule

`default_nettype wire

// File: sched_gen.sv
`timescale 1ns/10ps
`default_nettype none

module sched_gen #(
  parameter int num_dims = 4,
  localparam int sel_w = (num_dims > 1) ? $clog2(num_dims) : 1
) (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire                                  clk_en,
  input  wire                                  flush,
  input  wire                                  last,
  input  wire [sel_w-1:0]                      dim_sel,
  input  wire lake_pkg::cfg_word_t             cycle_count,
  input  wire lake_pkg::cfg_word_t             sched_start,
  input  wire lake_pkg::cfg_word_t [num_dims-1:0] sched_strides,
  output logic                                 valid
);

  import lake_pkg::*;

  acc_state_t state;
  cfg_word_t  sched_addr;

  // gate closes once the final iteration has been issued.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= acc_run;
    end else if (clk_en) begin
      if (flush) begin
        state <= acc_run;
      end else if (valid && last) begin
        state <= acc_done;
      end
    end
  end

  assign valid = (cycle_count == sched_addr) && (state == acc_run);

  // schedule time never restarts, the gate ends the sequence instead.
  addr_gen #(
    .num_dims(num_dims)
  ) sched_addr_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .clk_en    (clk_en),
    .flush     (flush),
    .step      (valid),
    .restart   (1'b0),
    .dim_sel   (dim_sel),
    .start_addr(sched_start),
    .strides   (sched_strides),
    .addr      (sched_addr)
  );

endmodule

`default_nettype wire

// File: weight_mem.sv
`timescale 1ns/10ps
`default_nettype none

module weight_mem (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     clk_en,
  input  wire                     flush,
  input  wire                     write,
  input  wire                     read,
  input  wire lake_pkg::mem_addr_t write_addr,
  input  wire lake_pkg::mem_addr_t read_addr,
  input  wire lake_pkg::data_t     data_in,
  output lake_pkg::data_t          data_out,
  output logic                    data_out_valid
);

  import lake_pkg::*;

  data_t     mem [mem_depth];
  mem_addr_t addr;
  logic      rd_fire;

  // single port, write wins.
  assign addr    = write ? write_addr : read_addr;
  assign rd_fire = read && !write && !flush;

  always_ff @(posedge clk) begin
    if (clk_en) begin
      if (write && !flush) begin
        mem[addr] <= data_in;
      end
      if (rd_fire) begin
        data_out <= mem[addr]; // holds between reads.
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_out_valid <= 1'b0;
    end else if (clk_en) begin
      data_out_valid <= rd_fire;
    end
  end

endmodule

`default_nettype wire

// File: lake_tile.sv
`timescale 1ns/10ps
`default_nettype none

module lake_tile #(
  parameter int num_dims = 4
) (
  input  wire                                  clk,
  input  wire                                  rst_n,
  input  wire                                  clk_en,
  input  wire                                  flush,
  input  wire lake_pkg::data_t                 data_in,
  input  wire lake_pkg::dim_cnt_t              wr_dimensionality,
  input  wire lake_pkg::cfg_word_t [num_dims-1:0] wr_ranges,
  input  wire lake_pkg::cfg_word_t             wr_start_addr,
  input  wire lake_pkg::cfg_word_t [num_dims-1:0] wr_strides,
  input  wire lake_pkg::cfg_word_t             wr_sched_start,
  input  wire lake_pkg::cfg_word_t [num_dims-1:0] wr_sched_strides,
  input  wire lake_pkg::dim_cnt_t              rd_dimensionality,
  input  wire lake_pkg::cfg_word_t [num_dims-1:0] rd_ranges,
  input  wire lake_pkg::cfg_word_t             rd_start_addr,
  input  wire lake_pkg::cfg_word_t [num_dims-1:0] rd_strides,
  input  wire lake_pkg::cfg_word_t             rd_sched_start,
  input  wire lake_pkg::cfg_word_t [num_dims-1:0] rd_sched_strides,
  output lake_pkg::data_t                      data_out,
  output logic                                 data_out_valid
);

  import lake_pkg::*;

  localparam int sel_w = (num_dims > 1) ? $clog2(num_dims) : 1;

  cfg_word_t  cycle_count;
  logic       wr_sched_valid;
  logic       wr_valid;
  logic       wr_last;
  logic [sel_w-1:0] wr_dim_sel;
  cfg_word_t  wr_addr;
  mem_addr_t  wr_mem_addr;
  logic       rd_sched_valid;
  logic       rd_valid;
  logic       rd_last;
  logic [sel_w-1:0] rd_dim_sel;
  cfg_word_t  rd_addr;
  mem_addr_t  rd_mem_addr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_count <= '0;
    end else if (clk_en) begin
      if (flush) begin
        cycle_count <= '0;
      end else begin
        cycle_count <= cycle_count + cfg_word_t'(1);
      end
    end
  end

  // an accessor with no dimensions never fires.
  assign wr_valid = wr_sched_valid && (wr_dimensionality != '0);
  assign rd_valid = rd_sched_valid && (rd_dimensionality != '0);

  assign wr_mem_addr = wr_addr[mem_addr_w-1:0];
  assign rd_mem_addr = rd_addr[mem_addr_w-1:0];

  // write accessor, data_in to memory.
  loop_iterator #(.num_dims(num_dims)) wr_iter (
    .clk(clk), .rst_n(rst_n), .clk_en(clk_en), .flush(flush),
    .step(wr_valid), .dimensionality(wr_dimensionality), .ranges(wr_ranges),
    .dim_sel(wr_dim_sel), .last(wr_last)
  );

  addr_gen #(.num_dims(num_dims)) wr_addr_gen (
    .clk(clk), .rst_n(rst_n), .clk_en(clk_en), .flush(flush),
    .step(wr_valid), .restart(wr_last), .dim_sel(wr_dim_sel),
    .start_addr(wr_start_addr), .strides(wr_strides), .addr(wr_addr)
  );

  sched_gen #(.num_dims(num_dims)) wr_sched (
    .clk(clk), .rst_n(rst_n), .clk_en(clk_en), .flush(flush),
    .last(wr_last), .dim_sel(wr_dim_sel), .cycle_count(cycle_count),
    .sched_start(wr_sched_start), .sched_strides(wr_sched_strides),
    .valid(wr_sched_valid)
  );

  // read accessor, memory to data_out.
  loop_iterator #(.num_dims(num_dims)) rd_iter (
    .clk(clk), .rst_n(rst_n), .clk_en(clk_en), .flush(flush),
    .step(rd_valid), .dimensionality(rd_dimensionality), .ranges(rd_ranges),
    .dim_sel(rd_dim_sel), .last(rd_last)
  );

  addr_gen #(.num_dims(num_dims)) rd_addr_gen (
    .clk(clk), .rst_n(rst_n), .clk_en(clk_en), .flush(flush),
    .step(rd_valid), .restart(rd_last), .dim_sel(rd_dim_sel),
    .start_addr(rd_start_addr), .strides(rd_strides), .addr(rd_addr)
  );

  sched_gen #(.num_dims(num_dims)) rd_sched (
    .clk(clk), .rst_n(rst_n), .clk_en(clk_en), .flush(flush),
    .last(rd_last), .dim_sel(rd_dim_sel), .cycle_count(cycle_count),
    .sched_start(rd_sched_start), .sched_strides(rd_sched_strides),
    .valid(rd_sched_valid)
  );

  weight_mem weight_mem_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .clk_en        (clk_en),
    .flush         (flush),
    .write         (wr_valid),
    .read          (rd_valid),
    .write_addr    (wr_mem_addr),
    .read_addr     (rd_mem_addr),
    .data_in       (data_in),
    .data_out      (data_out),
    .data_out_valid(data_out_valid)
  );

endmodule

`default_nettype wire

// File: lake_tile_props.sv
`timescale 1ns/10ps
`default_nettype none

module lake_tile_props (
  input wire clk,
  input wire rst_n,
  input wire clk_en,
  input wire flush,
  input wire write,
  input wire read,
  input wire data_out_valid
);

  int fail_count;

  initial fail_count = 0;

  // single port, the two schedules must stay apart.
  port_conflict: assert property (@(posedge clk) disable iff (!rst_n) !(write && read))
    else begin
      fail_count++;
      $error("write and read issued in the same cycle");
    end

  read_latency: assert property (@(posedge clk) disable iff (!rst_n)
    clk_en |=> (data_out_valid == $past(read && !flush)))
    else begin
      fail_count++;
      $error("data_out_valid does not follow read by one enabled edge");
    end

  stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !clk_en |=> $stable(data_out_valid))
    else begin
      fail_count++;
      $error("data_out_valid changed during a stall");
    end

  reset_low: assert property (@(posedge clk) !rst_n |-> !data_out_valid)
    else begin
      fail_count++;
      $error("data_out_valid high during reset");
    end

endmodule

bind weight_mem lake_tile_props props_inst (
  .clk(clk), .rst_n(rst_n), .clk_en(clk_en), .flush(flush),
  .write(write), .read(read), .data_out_valid(data_out_valid)
);

`default_nettype wire

// File: tb_lake_tile.sv
`timescale 1ns/10ps
`default_nettype none

module tb_lake_tile;

  import lake_pkg::*;

  localparam int num_dims = 4;
  localparam int sel_w    = (num_dims > 1) ? $clog2(num_dims) : 1;
  localparam int num_rows = 6;
  localparam int tail     = 8; // idle cycles after the last scheduled event.

  typedef struct packed {
    dim_cnt_t                 dims;
    cfg_word_t [num_dims-1:0] ranges;
    cfg_word_t                start;
    cfg_word_t [num_dims-1:0] strides;
    cfg_word_t                sstart;
    cfg_word_t [num_dims-1:0] sstrides;
  } acc_cfg_t;

  typedef struct packed {
    acc_cfg_t  wr;
    acc_cfg_t  rd;
    cfg_word_t stall_at;
    cfg_word_t stall_len;
    cfg_word_t flush_at; // zero means no flush during the run.
    cfg_word_t exp_reads;
  } row_t;

  logic                     clk;
  logic                     rst_n;
  logic                     clk_en;
  logic                     flush;
  data_t                    data_in;
  dim_cnt_t                 wr_dimensionality;
  cfg_word_t [num_dims-1:0] wr_ranges;
  cfg_word_t                wr_start_addr;
  cfg_word_t [num_dims-1:0] wr_strides;
  cfg_word_t                wr_sched_start;
  cfg_word_t [num_dims-1:0] wr_sched_strides;
  dim_cnt_t                 rd_dimensionality;
  cfg_word_t [num_dims-1:0] rd_ranges;
  cfg_word_t                rd_start_addr;
  cfg_word_t [num_dims-1:0] rd_strides;
  cfg_word_t                rd_sched_start;
  cfg_word_t [num_dims-1:0] rd_sched_strides;
  data_t                    data_out;
  logic                     data_out_valid;

  row_t      rows [num_rows];
  row_t      cur;
  data_t     mirror [mem_depth]; // model of the weight memory.
  cfg_word_t wr_t_q [$];
  mem_addr_t wr_a_q [$];
  cfg_word_t rd_t_q [$];
  mem_addr_t rd_a_q [$];
  cfg_word_t model_cycle;
  logic      exp_valid;
  data_t     exp_data;
  logic      edge_en;
  integer    seed;
  int        errors;
  int        checks;

  lake_tile #(.num_dims(num_dims)) lake_tile_inst (
    .clk(clk), .rst_n(rst_n), .clk_en(clk_en), .flush(flush), .data_in(data_in),
    .wr_dimensionality(wr_dimensionality), .wr_ranges(wr_ranges),
    .wr_start_addr(wr_start_addr), .wr_strides(wr_strides),
    .wr_sched_start(wr_sched_start), .wr_sched_strides(wr_sched_strides),
    .rd_dimensionality(rd_dimensionality), .rd_ranges(rd_ranges),
    .rd_start_addr(rd_start_addr), .rd_strides(rd_strides),
    .rd_sched_start(rd_sched_start), .rd_sched_strides(rd_sched_strides),
    .data_out(data_out), .data_out_valid(data_out_valid)
  );

  always #50 clk = ~clk;

  task automatic check_data(input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t data_out is %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_valid(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t data_out_valid is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[FAIL] %0t %0d valid reads, expected %0d", $time, got, exp);
    end
  endtask

  function automatic acc_cfg_t acc2d(input cfg_word_t n0, input cfg_word_t n1,
                                     input cfg_word_t start, input cfg_word_t s0,
                                     input cfg_word_t s1, input cfg_word_t sstart,
                                     input cfg_word_t t0, input cfg_word_t t1);
    acc_cfg_t a;
    a             = '0;
    a.dims        = (n1 > 16'd1) ? 4'd2 : 4'd1;
    a.ranges[0]   = n0 - 16'd1; // range is count minus one.
    a.ranges[1]   = n1 - 16'd1;
    a.start       = start;
    a.strides[0]  = s0;
    a.strides[1]  = s1;
    a.sstart      = sstart;
    a.sstrides[0] = t0;
    a.sstrides[1] = t1;
    return a;
  endfunction

  function automatic acc_cfg_t acc1d(input cfg_word_t n, input cfg_word_t start,
                                     input cfg_word_t stride, input cfg_word_t sstart,
                                     input cfg_word_t sstride);
    return acc2d(n, 16'd1, start, stride, 16'd0, sstart, sstride, 16'd0);
  endfunction

  function automatic acc_cfg_t acc_off(input cfg_word_t sstart);
    acc_cfg_t a;
    a        = '0;
    a.sstart = sstart; // dimensionality zero.
    return a;
  endfunction

  function automatic row_t make_row(input acc_cfg_t wr, input acc_cfg_t rd,
                                    input cfg_word_t stall_at, input cfg_word_t stall_len,
                                    input cfg_word_t flush_at, input cfg_word_t exp_reads);
    row_t r;
    r.wr        = wr;
    r.rd        = rd;
    r.stall_at  = stall_at;
    r.stall_len = stall_len;
    r.flush_at  = flush_at;
    r.exp_reads = exp_reads;
    return r;
  endfunction

  // steps the loop nest; returns the last scheduled time.
  function automatic int walk(input acc_cfg_t a, input bit to_rd, input bit keep);
    cfg_word_t [num_dims-1:0] cnt;
    cfg_word_t                t;
    cfg_word_t                off;
    logic [sel_w-1:0]         sel;
    logic                     found;
    int                       n_dims;
    n_dims = (int'(a.dims) > num_dims) ? num_dims : int'(a.dims);
    if (n_dims == 0) begin
      return 0;
    end
    cnt = '0;
    t   = a.sstart;
    off = '0;
    sel = '0;
    while (1'b1) begin
      if (keep && to_rd) begin
        rd_t_q.push_back(t);
        rd_a_q.push_back(mem_addr_t'(a.start + off));
      end else if (keep) begin
        wr_t_q.push_back(t);
        wr_a_q.push_back(mem_addr_t'(a.start + off));
      end
      found = 1'b0;
      for (int d = 0; d < n_dims; d++) begin
        if (!found && cnt[sel_w'(d)] != a.ranges[sel_w'(d)]) begin
          found = 1'b1;
          sel   = sel_w'(d);
        end
      end
      if (!found) begin
        break; // every active dimension at its range.
      end
      for (int d = 0; d < int'(sel); d++) begin
        cnt[sel_w'(d)] = '0;
      end
      cnt[sel] = cnt[sel] + 16'd1;
      t        = t + a.sstrides[sel];
      off      = off + a.strides[sel];
    end
    return int'(t);
  endfunction

  function automatic int row_cycles(input row_t row);
    int wr_end;
    int rd_end;
    int span;
    wr_end = walk(row.wr, 1'b0, 1'b0);
    rd_end = walk(row.rd, 1'b1, 1'b0);
    span   = ((wr_end > rd_end) ? wr_end : rd_end) + 2 + int'(row.stall_len) + tail;
    if (row.flush_at != '0) begin
      span += int'(row.flush_at) + 1;
    end
    return span;
  endfunction

  function automatic void rebuild();
    wr_t_q.delete();
    wr_a_q.delete();
    rd_t_q.delete();
    rd_a_q.delete();
    void'(walk(cur.wr, 1'b0, 1'b1));
    void'(walk(cur.rd, 1'b1, 1'b1));
    model_cycle = '0;
    exp_valid   = 1'b0;
  endfunction

  task automatic apply_cfg(input row_t row);
    wr_dimensionality = row.wr.dims;
    wr_ranges         = row.wr.ranges;
    wr_start_addr     = row.wr.start;
    wr_strides        = row.wr.strides;
    wr_sched_start    = row.wr.sstart;
    wr_sched_strides  = row.wr.sstrides;
    rd_dimensionality = row.rd.dims;
    rd_ranges         = row.rd.ranges;
    rd_start_addr     = row.rd.start;
    rd_strides        = row.rd.strides;
    rd_sched_start    = row.rd.sstart;
    rd_sched_strides  = row.rd.sstrides;
  endtask

  // checks the outputs mid-cycle, then models the edge that ends the cycle.
  task automatic step_cycle(inout int reads);
    @(negedge clk);
    check_valid(data_out_valid, exp_valid);
    if (exp_valid) begin
      check_data(data_out, exp_data);
    end
    if (data_out_valid && edge_en) begin
      reads++;
    end
    @(posedge clk);
    edge_en = clk_en;
    if (clk_en && flush) begin
      rebuild();
    end else if (clk_en) begin
      if (wr_t_q.size() > 0 && wr_t_q[0] == model_cycle) begin
        mirror[wr_a_q[0]] = data_in;
        void'(wr_t_q.pop_front());
        void'(wr_a_q.pop_front());
      end
      exp_valid = 1'b0;
      if (rd_t_q.size() > 0 && rd_t_q[0] == model_cycle) begin
        exp_valid = 1'b1;
        exp_data  = mirror[rd_a_q[0]];
        void'(rd_t_q.pop_front());
        void'(rd_a_q.pop_front());
      end
      model_cycle = model_cycle + 16'd1;
    end
    #5;
  endtask

  task automatic run_row(input int r);
    int reads;
    int n;
    int e0;
    reads = 0;
    e0    = errors;
    cur   = rows[r];
    n     = row_cycles(cur);
    apply_cfg(cur);
    flush   = 1'b1;
    clk_en  = 1'b1;
    data_in = {$random(seed), $random(seed)};
    step_cycle(reads);
    for (int c = 0; c < n; c++) begin
      clk_en  = !(c >= int'(cur.stall_at) &&
                  c < int'(cur.stall_at) + int'(cur.stall_len));
      flush   = (cur.flush_at != '0) && (c == int'(cur.flush_at));
      data_in = {$random(seed), $random(seed)};
      step_cycle(reads);
    end
    check_count(reads, int'(cur.exp_reads));
    $display("test %0d: %0d reads of %0d, %s", r, reads, cur.exp_reads,
             (errors == e0) ? "ok" : "mismatches");
  endtask

  task automatic load_table();
    rows[0] = make_row(acc1d(16'd8, 16'd0, 16'd1, 16'd2, 16'd1),
                       acc1d(16'd8, 16'd0, 16'd1, 16'd12, 16'd1),
                       16'd0, 16'd0, 16'd0, 16'd8);
    // read walks the write pattern transposed.
    rows[1] = make_row(acc2d(16'd4, 16'd2, 16'd32, 16'd2, 16'd3, 16'd2, 16'd1, 16'd1),
                       acc2d(16'd2, 16'd4, 16'd32, 16'd9, 16'hfff9, 16'd12, 16'd1, 16'd1),
                       16'd0, 16'd0, 16'd0, 16'd8);
    rows[2] = make_row(acc_off(16'd1), acc1d(16'd6, 16'd0, 16'd1, 16'd4, 16'd3),
                       16'd0, 16'd0, 16'd0, 16'd6);
    rows[3] = make_row(acc_off(16'd2), acc_off(16'd5), 16'd0, 16'd0, 16'd0, 16'd0);
    rows[4] = make_row(acc1d(16'd8, 16'd0, 16'd1, 16'd2, 16'd1),
                       acc1d(16'd8, 16'd0, 16'd1, 16'd12, 16'd1),
                       16'd14, 16'd5, 16'd0, 16'd8);
    // three reads before the flush, then the full rerun.
    rows[5] = make_row(acc1d(16'd8, 16'd0, 16'd1, 16'd2, 16'd1),
                       acc1d(16'd8, 16'd0, 16'd1, 16'd12, 16'd1),
                       16'd0, 16'd0, 16'd15, 16'd11);
  endtask

  initial begin
    seed              = 32'h60b6_82f0;
    errors            = 0;
    checks            = 0;
    clk               = 1'b0;
    rst_n             = 1'b0;
    clk_en            = 1'b0;
    flush             = 1'b0;
    data_in           = '0;
    wr_dimensionality = '0;
    wr_ranges         = '0;
    wr_start_addr     = '0;
    wr_strides        = '0;
    wr_sched_start    = '0;
    wr_sched_strides  = '0;
    rd_dimensionality = '0;
    rd_ranges         = '0;
    rd_start_addr     = '0;
    rd_strides        = '0;
    rd_sched_start    = '0;
    rd_sched_strides  = '0;
    model_cycle       = '0;
    exp_valid         = 1'b0;
    exp_data          = '0;
    edge_en           = 1'b0;
    load_table();
    repeat (16) @(posedge clk);
    #5;
    rst_n = 1'b1;
    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end
    if (lake_tile_inst.weight_mem_inst.props_inst.fail_count != 0) begin
      $display("memory port assertions failed %0d times",
               lake_tile_inst.weight_mem_inst.props_inst.fail_count);
      errors += lake_tile_inst.weight_mem_inst.props_inst.fail_count;
    end
    $display("%0d tests, %0d checks, %0d errors", num_rows, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    #1;
    limit = 16;
    for (int r = 0; r < num_rows; r++) begin
      limit += 2 * (row_cycles(rows[r]) + 1);
    end
    repeat (limit) @(posedge clk);
    $display("timeout, the run did not end within %0d clock periods", limit);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
lake_pkg.sv
loop_iterator.sv
addr_gen.sv
sched_gen.sv
weight_mem.sv
lake_tile.sv
lake_tile_props.sv
tb_lake_tile.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_lake_tile \
  -f sources.f -o tb_lake_tile_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/tb_lake_tile_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" sim.log; then
  exit 1
fi
exit 0
